// File: all.f
+incdir+design
design/sifhPkg.sv
design/binSram.sv
design/histBuilder.sv
design/peakFinder.sv
design/sifhTop.sv
test/clockGen.sv
test/sifhTb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module sifhTb -f all.f --Mdir "$BUILD" -o simv
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// File: test/sifhTb.sv
`include "sifh_defines.svh"

module sifhTb
    import sifhPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumEvt = `EVENTS_PER_PASS;
    localparam int MaxCount = (1 << `CNT_W) - 1;
    localparam int LowW = `TS_W - 2 * `BIN_AW;
    localparam int BinMask = `BIN_NUM - 1;
    localparam int WaitLimit = 400;   // cycles, longer than any clear plus search gap

    typedef tdcEvent_t evtSet_t [NumEvt];
    typedef int histArr_t [`BIN_NUM];

    logic        clk;
    logic        res;
    logic        start;
    tdcEvent_t   evt;
    logic        evtValid;
    logic        evtReady;
    sifhResult_t result;
    logic        resultValid;

    integer      seed = 32'hb629_6109;
    int          checkCount = 0;
    int          mismatchCount = 0;
    int          otherErrors = 0;
    int          resultCount = 0;
    int          transferCount = 0;   // transfers in the current ready window
    logic        readyWasHigh = 1'b0;
    sifhResult_t expQ [$];

    clockGen clockGen_inst (
        .clk (clk),
        .res (res)
    );

    sifhTop sifhTop_inst (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .evt         (evt),
        .evtValid    (evtValid),
        .evtReady    (evtReady),
        .result      (result),
        .resultValid (resultValid)
    );

    function automatic peak_t pickPeak(input histArr_t hist);
        peak_t p;
        p.bin   = '0;
        p.count = '0;
        for (int b = 0; b < `BIN_NUM; b++) begin
            if (hist[b] > int'(p.count)) begin   // strictly higher, lowest bin keeps a tie
                p.bin   = binAddr_t'(b);
                p.count = binCount_t'(hist[b]);
            end
        end
        return p;
    endfunction

    function automatic sifhResult_t expectResult(input evtSet_t coarseSet,
                                                 input evtSet_t fineSet);
        histArr_t    hist;
        sifhResult_t r;
        binAddr_t    c;
        binAddr_t    f;
        foreach (hist[b]) hist[b] = 0;
        for (int i = 0; i < NumEvt; i++) begin
            c = coarseSet[i][`TS_W-1 -: `BIN_AW];
            if (hist[c] < MaxCount) hist[c]++;
        end
        r.coarse = pickPeak(hist);
        foreach (hist[b]) hist[b] = 0;
        for (int i = 0; i < NumEvt; i++) begin
            c = fineSet[i][`TS_W-1 -: `BIN_AW];
            f = fineSet[i][`TS_W-`BIN_AW-1 -: `BIN_AW];
            if (c == r.coarse.bin && hist[f] < MaxCount) hist[f]++;   // coarse window only
        end
        r.fine = pickPeak(hist);
        return r;
    endfunction

    function automatic tdcEvent_t makeEvt(input int c, input int f, input int low);
        return {binAddr_t'(c), binAddr_t'(f), LowW'(low)};
    endfunction

    // bias 0 gives uniform timestamps, 3 puts most events near the centers
    task automatic makeSet(output evtSet_t s, input int center, input int fineCenter,
                           input int bias);
        int c;
        int f;
        for (int i = 0; i < NumEvt; i++) begin
            c = (($random(seed) & 3) < bias) ? center : ($random(seed) & BinMask);
            f = (($random(seed) & 3) < bias) ? fineCenter : ($random(seed) & BinMask);
            s[i] = makeEvt(c, f, $random(seed));
        end
    endtask

    task automatic checkPeak(input string what, input peak_t got, input peak_t exp);
        checkCount++;
        if (got !== exp) begin
            mismatchCount++;
            $display("Mismatch at %0t: %s peak bin %0d count %0d, expected bin %0d count %0d",
                     $time, what, got.bin, got.count, exp.bin, exp.count);
        end
    endtask

    task automatic checkResult(input sifhResult_t got, input sifhResult_t exp);
        checkPeak("coarse", got.coarse, exp.coarse);
        checkPeak("fine", got.fine, exp.fine);
    endtask

    task automatic checkTransfers(input int got);
        checkCount++;
        if (got != NumEvt) begin
            mismatchCount++;
            $display("Mismatch at %0t: %0d transfers in one pass, expected %0d",
                     $time, got, NumEvt);
        end
    endtask

    task automatic checkLow(input string what, input logic value);
        checkCount++;
        if (value !== 1'b0) begin
            mismatchCount++;
            $display("Mismatch at %0t: %s is %b before start, expected 0", $time, what, value);
        end
    endtask

    task automatic endRun();
        $display("checks %0d, mismatches %0d, other errors %0d", checkCount, mismatchCount,
                 otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic abortRun(input string why);
        otherErrors++;
        $display("Error at %0t: %s", $time, why);
        endRun();
    endtask

    // one offer per cycle, an offer stays up until it is taken
    task automatic sendEvents(input evtSet_t evts, input bit stalls);
        int   idx;
        int   idleCycles;
        logic fire;
        idx = 0;
        idleCycles = 0;
        while (idx < NumEvt) begin
            if (!evtValid && !(stalls && (($random(seed) & 3) == 0))) begin
                evt      = evts[idx];
                evtValid = 1'b1;
            end
            @(negedge clk);
            fire = evtValid && evtReady;
            @(posedge clk);
            #1;
            if (fire) begin
                idx++;
                evtValid   = 1'b0;
                idleCycles = 0;
            end else begin
                idleCycles++;
                if (idleCycles > WaitLimit) abortRun("evtReady stayed low during a pass");
            end
        end
    endtask

    task automatic runMeasurement(input evtSet_t coarseSet, input evtSet_t fineSet,
                                  input bit stalls);
        int target;
        int waitCycles;
        target = resultCount + 1;
        expQ.push_back(expectResult(coarseSet, fineSet));
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        sendEvents(coarseSet, stalls);
        sendEvents(fineSet, stalls);
        waitCycles = 0;
        while (resultCount < target) begin
            @(posedge clk);
            #1;
            waitCycles++;
            if (waitCycles > WaitLimit) abortRun("no resultValid after the fine pass");
        end
    endtask

    always @(negedge clk) begin
        if (res && resultValid) begin
            resultCount++;
            if (expQ.size() == 0) begin
                otherErrors++;
                $display("Error at %0t: resultValid with no measurement pending", $time);
            end else begin
                checkResult(result, expQ.pop_front());
            end
        end
    end

    // one ready window per build pass
    always @(negedge clk) begin
        if (res && evtReady) begin
            readyWasHigh = 1'b1;
            if (evtValid) transferCount++;
        end else if (readyWasHigh) begin
            checkTransfers(transferCount);
            transferCount = 0;
            readyWasHigh  = 1'b0;
        end
    end

    initial begin
        evtSet_t coarseSet;
        evtSet_t fineSet;
        int      waitCycles;
        start      = 1'b0;
        evt        = '0;
        evtValid   = 1'b0;
        waitCycles = 0;
        while (res !== 1'b1) begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > 100) abortRun("reset was never released");
        end
        repeat (20) begin
            @(negedge clk);
            checkLow("evtReady", evtReady);
            checkLow("resultValid", resultValid);
        end
        @(posedge clk);
        #1;

        makeSet(coarseSet, 0, 0, 0);   // uniform timestamps, no stalls
        makeSet(fineSet, 0, 0, 0);
        runMeasurement(coarseSet, fineSet, 1'b0);
        makeSet(coarseSet, 6, 11, 3);
        makeSet(fineSet, 6, 11, 3);
        runMeasurement(coarseSet, fineSet, 1'b0);

        makeSet(coarseSet, 12, 3, 3);   // source stalls
        makeSet(fineSet, 12, 3, 3);
        runMeasurement(coarseSet, fineSet, 1'b1);
        makeSet(coarseSet, 0, 0, 0);
        makeSet(fineSet, 0, 0, 0);
        runMeasurement(coarseSet, fineSet, 1'b1);

        // fine events mostly outside the window, the largest cluster must not count
        for (int i = 0; i < NumEvt; i++) begin
            coarseSet[i] = (i < 40) ? makeEvt(5, i % 16, i) : makeEvt(i % 5, 0, i);
            fineSet[i]   = (i < 8) ? makeEvt(5, 7, i) :
                           (i < 12) ? makeEvt(5, 2, i) : makeEvt(10, 3, i);
        end
        runMeasurement(coarseSet, fineSet, 1'b0);

        for (int i = 0; i < NumEvt; i++) begin   // coarse and fine ties
            coarseSet[i] = (i % 2 == 0) ? makeEvt(9, 1, i) : makeEvt(3, 1, i);
            fineSet[i]   = (i < 20) ? makeEvt(3, 12, i) :
                           (i < 40) ? makeEvt(3, 4, i) : makeEvt(9, 0, i);
        end
        runMeasurement(coarseSet, fineSet, 1'b0);

        for (int i = 0; i < NumEvt; i++) begin   // one bin, past saturation
            coarseSet[i] = makeEvt(10, 5, 12);
            fineSet[i]   = makeEvt(10, 5, 12);
        end
        runMeasurement(coarseSet, fineSet, 1'b0);
        makeSet(coarseSet, 2, 9, 2);
        makeSet(fineSet, 2, 9, 2);
        runMeasurement(coarseSet, fineSet, 1'b1);

        if (expQ.size() != 0) begin
            otherErrors++;
            $display("Error: %0d expected results never arrived", expQ.size());
        end
        endRun();
    end

endmodule

// File: test/clockGen.sv
module clockGen (
    output logic clk,
    output logic res
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // reset released just after the 16th rising edge
    initial begin
        res = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        res = 1'b1;
    end

endmodule

// File: design/sifhTop.sv
`include "sifh_defines.svh"

module sifhTop
    import sifhPkg::*;
(
    input  logic        clk,
    input  logic        res,
    input  logic        start,
    input  tdcEvent_t   evt,
    input  logic        evtValid,
    output logic        evtReady,
    output sifhResult_t result,
    output logic        resultValid
);

    typedef enum logic [3:0] {
        idle,
        clearCoarse,
        buildCoarse,
        searchCoarse,
        latchWindow,
        clearFine,
        buildFine,
        searchFine,
        report
    } phase_t;

    phase_t    state;
    phase_t    nextState;

    logic      clearStart;
    logic      clearDone;
    logic      buildDone;
    logic      searchDone;
    logic      evtFire;
    binAddr_t  coarseField;
    binAddr_t  fineField;
    binAddr_t  binSel;
    logic      binHit;
    peak_t     coarsePeak;   // also the fine-pass window
    peak_t     pfPeak;
    ramReq_t   hbReq;
    ramReq_t   pfReq;
    ramReq_t   ramReq;
    binCount_t rdData;

    assign evtFire     = evtValid && evtReady;
    assign clearStart  = (state == idle && start) || (state == latchWindow);
    assign resultValid = (state == report);

    assign coarseField = evt[`TS_W-1 -: `BIN_AW];
    assign fineField   = evt[`TS_W-`BIN_AW-1 -: `BIN_AW];
    assign binSel      = (state == buildFine) ? fineField : coarseField;
    assign binHit      = (state == buildFine) ? (coarseField == coarsePeak.bin) : 1'b1;

    always_comb begin
        nextState = state;
        case (state)
            idle:         if (start) nextState = clearCoarse;
            clearCoarse:  if (clearDone) nextState = buildCoarse;
            buildCoarse:  if (buildDone) nextState = searchCoarse;
            searchCoarse: if (searchDone) nextState = latchWindow;
            latchWindow:  nextState = clearFine;
            clearFine:    if (clearDone) nextState = buildFine;
            buildFine:    if (buildDone) nextState = searchFine;
            searchFine:   if (searchDone) nextState = report;
            report:       nextState = idle;
            default:      nextState = idle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == latchWindow) coarsePeak <= pfPeak;
        if (state == searchFine && searchDone) begin
            result.coarse <= coarsePeak;
            result.fine   <= pfPeak;
        end
    end

    // memory ownership follows the phase
    always_comb begin
        case (state)
            clearCoarse, buildCoarse, clearFine, buildFine: ramReq = hbReq;
            searchCoarse, searchFine:                         ramReq = pfReq;
            default:                                          ramReq = '0;
        endcase
    end

    binSram binSram_inst (
        .clk    (clk),
        .req    (ramReq),
        .rdData (rdData)
    );

    histBuilder histBuilder_inst (
        .clk        (clk),
        .res        (res),
        .clearStart (clearStart),
        .buildStart (clearDone),   // build follows straight after the sweep
        .evt        (evt),
        .evtFire    (evtFire),
        .binSel     (binSel),
        .binHit     (binHit),
        .rdData     (rdData),
        .req        (hbReq),
        .evtReady   (evtReady),
        .clearDone  (clearDone),
        .buildDone  (buildDone)
    );

    peakFinder peakFinder_inst (
        .clk    (clk),
        .res    (res),
        .start  (buildDone),
        .rdData (rdData),
        .req    (pfReq),
        .peak   (pfPeak),
        .done   (searchDone)
    );

    assert property (@(posedge clk) disable iff (!res)
        !((hbReq.rdEn || hbReq.wrEn) && (pfReq.rdEn || pfReq.wrEn)));

    // an active submodule always holds the memory port
    assert property (@(posedge clk) disable iff (!res)
        (hbReq.rdEn || hbReq.wrEn || pfReq.rdEn) |-> (ramReq != '0));

endmodule

// File: design/peakFinder.sv
`include "sifh_defines.svh"

module peakFinder
    import sifhPkg::*;
(
    input  logic      clk,
    input  logic      res,
    input  logic      start,
    input  binCount_t rdData,
    output ramReq_t   req,
    output peak_t     peak,
    output logic      done
);

    localparam binAddr_t lastBin = binAddr_t'(`BIN_NUM - 1);

    logic      scanning;
    binAddr_t  rdAddr;
    logic      dataValid;   // rdData belongs to dataAddr
    binAddr_t  dataAddr;
    binAddr_t  bestBin;
    binCount_t bestCount;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning  <= 1'b0;
            rdAddr    <= '0;
            dataValid <= 1'b0;
            done      <= 1'b0;
        end else begin
            dataValid <= scanning;
            done      <= dataValid && (dataAddr == lastBin);
            if (start) begin
                scanning <= 1'b1;
                rdAddr   <= '0;
            end else if (scanning) begin
                rdAddr <= rdAddr + 1'b1;
                if (rdAddr == lastBin) scanning <= 1'b0;
            end
        end
    end

    // strict compare so ties keep the lower bin
    always_ff @(posedge clk) begin
        dataAddr <= rdAddr;
        if (start) begin
            bestBin   <= '0;
            bestCount <= '0;
        end else if (dataValid && rdData > bestCount) begin
            bestBin   <= dataAddr;
            bestCount <= rdData;
        end
    end

    always_comb begin
        req        = '0;
        req.rdEn   = scanning;
        req.rdAddr = rdAddr;
        peak.bin   = bestBin;
        peak.count = bestCount;
    end

    assert property (@(posedge clk) disable iff (!res)
        done |-> (!req.rdEn && $past(!req.rdEn)));

endmodule

// File: design/histBuilder.sv
`include "sifh_defines.svh"

module histBuilder
    import sifhPkg::*;
(
    input  logic      clk,
    input  logic      res,
    input  logic      clearStart,
    input  logic      buildStart,
    input  tdcEvent_t evt,
    input  logic      evtFire,
    input  binAddr_t  binSel,
    input  logic      binHit,
    input  binCount_t rdData,
    output ramReq_t   req,
    output logic      evtReady,
    output logic      clearDone,
    output logic      buildDone
);

    localparam int EvtCntW = $clog2(`EVENTS_PER_PASS + 1);
    localparam logic [EvtCntW-1:0] evtTotal = EvtCntW'(`EVENTS_PER_PASS);
    localparam binAddr_t lastBin = binAddr_t'(`BIN_NUM - 1);
    localparam binCount_t maxCount = '1;

    logic               clearing;
    binAddr_t           clrAddr;
    logic               building;
    logic [EvtCntW-1:0] evtCnt;

    logic      s1Valid;       // increment waiting for its read data
    binAddr_t  s1Addr;
    logic      lastWrValid;   // bin written in the previous cycle
    binAddr_t  lastWrAddr;
    binCount_t lastWrData;
    binCount_t base;
    binCount_t incCount;

    assign evtReady  = building && (evtCnt < evtTotal);
    assign clearDone = clearing && (clrAddr == lastBin);

    // memory still holds the old word if the previous cycle wrote this bin
    assign base     = (lastWrValid && lastWrAddr == s1Addr) ? lastWrData : rdData;
    assign incCount = (base == maxCount) ? base : binCount_t'(base + 1'b1);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearing    <= 1'b0;
            clrAddr     <= '0;
            building    <= 1'b0;
            evtCnt      <= '0;
            buildDone   <= 1'b0;
            s1Valid     <= 1'b0;
            lastWrValid <= 1'b0;
        end else begin
            buildDone   <= 1'b0;
            s1Valid     <= req.rdEn;
            lastWrValid <= s1Valid;
            if (clearStart) begin
                clearing <= 1'b1;
                clrAddr  <= '0;
            end else if (clearing) begin
                clrAddr <= clrAddr + 1'b1;
                if (clearDone) clearing <= 1'b0;
            end
            if (buildStart) begin
                building <= 1'b1;
                evtCnt   <= '0;
            end else if (building) begin
                if (evtFire) evtCnt <= evtCnt + 1'b1;
                if (evtCnt == evtTotal) begin   // last write goes out this cycle
                    building  <= 1'b0;
                    buildDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        s1Addr     <= binSel;
        lastWrAddr <= s1Addr;
        lastWrData <= incCount;
    end

    always_comb begin
        req = '0;
        if (clearing) begin
            req.wrEn   = 1'b1;
            req.wrAddr = clrAddr;
            req.wrData = '0;
        end else begin
            req.rdEn   = evtFire && binHit;
            req.rdAddr = binSel;
            req.wrEn   = s1Valid;
            req.wrAddr = s1Addr;
            req.wrData = incCount;
        end
    end

    // ready stays closed while a sweep owns the memory
    assert property (@(posedge clk) disable iff (!res)
        evtReady |-> !clearing);

    // forwarding keeps every bin monotonic across back-to-back hits
    assert property (@(posedge clk) disable iff (!res)
        (req.wrEn && $past(req.wrEn) && req.wrAddr == $past(req.wrAddr))
        |-> (req.wrData > $past(req.wrData) || $past(req.wrData) == maxCount));

    assert property (@(posedge clk) disable iff (!res)
        evtFire |-> (evtReady && !$isunknown(evt)));

endmodule

// File: design/binSram.sv
`include "sifh_defines.svh"

module binSram
    import sifhPkg::*;
(
    input  logic      clk,
    input  ramReq_t   req,
    output binCount_t rdData
);

    binCount_t mem [`BIN_NUM];

    // write port
    always_ff @(posedge clk) begin
        if (req.wrEn) begin
            mem[req.wrAddr] <= req.wrData;
        end
    end

    // registered read port, returns the pre-write word on a same-address collision
    always_ff @(posedge clk) begin
        if (req.rdEn) begin
            rdData <= mem[req.rdAddr];
        end
    end

endmodule

// File: design/sifhPkg.sv
`include "sifh_defines.svh"

package sifhPkg;

    typedef logic [`TS_W-1:0] tdcEvent_t;     // raw photon timestamp

    typedef logic [`BIN_AW-1:0] binAddr_t;    // bin index

    typedef logic [`CNT_W-1:0] binCount_t;    // bin occupancy

    // one cycle worth of memory control
    typedef struct packed {
        logic      rdEn;
        binAddr_t  rdAddr;
        logic      wrEn;
        binAddr_t  wrAddr;
        binCount_t wrData;
    } ramReq_t;

    typedef struct packed {
        binAddr_t  bin;
        binCount_t count;
    } peak_t;

    // two-pass measurement outcome
    typedef struct packed {
        peak_t coarse;
        peak_t fine;     // bin inside the coarse window
    } sifhResult_t;

endpackage

// File: design/sifh_defines.svh
`ifndef SIFH_DEFINES_SVH
`define SIFH_DEFINES_SVH

// timestamp word from the TDC
`define TS_W 12

// histogram geometry, coarse and fine passes use the same number of bins
`define BIN_AW 4
`define BIN_NUM 16

// events accepted in each build pass
`define EVENTS_PER_PASS 64

// bin counter width, counts saturate at all ones
`define CNT_W 6

`endif
